//--- rtl/mem_config.svh
// main memory configuration
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// ---------------------------------------------------------------------------
// word and address geometry
// ---------------------------------------------------------------------------

// bus and memory word width
`define MEM_DATA_W 32

// bus byte address width
`define MEM_ADDR_W 32

// ---------------------------------------------------------------------------
// sram size
// ---------------------------------------------------------------------------

// words held in the shared sram
`define MEM_LINES 1024

// line index width, log2 of MEM_LINES
`define MEM_LINE_W 10

// byte address bits 1:0 select a byte within a word,
// so the line index sits at bits MEM_LINE_W+1:2
// any address with word index >= MEM_LINES is answered with an error

`endif

//--- rtl/ahb_lite_pkg.sv
// ahb-lite bus types
`include "mem_config.svh"

package ahb_lite_pkg;

  // -------------------------------------------------------------------------
  // response encoding
  // -------------------------------------------------------------------------

  // single bit hresp, only okay and error are used
  localparam logic hresp_okay  = 1'b0;
  localparam logic hresp_error = 1'b1;

  // -------------------------------------------------------------------------
  // master to slave
  // -------------------------------------------------------------------------

  // request held by the master from hsel until hreadyout
  typedef struct packed
  {
    // byte address, word aligned for a legal access
    logic [`MEM_ADDR_W-1:0] haddr;
    // 1 for write
    logic                   hwrite;
    // write word, full word only
    logic [`MEM_DATA_W-1:0] hwdata;
  } mas_send_type;

  // -------------------------------------------------------------------------
  // slave to master
  // -------------------------------------------------------------------------

  // response, valid for the single cycle with hreadyout high
  typedef struct packed
  {
    // one cycle completion pulse
    logic                   hreadyout;
    // 1 means error
    logic                   hresp;
    // read word, undefined on write or error
    logic [`MEM_DATA_W-1:0] hrdata;
  } slv_send_type;

endpackage

//--- rtl/mem_pkg.sv
// memory side types
`include "mem_config.svh"

package mem_pkg;

  // -------------------------------------------------------------------------
  // storage types
  // -------------------------------------------------------------------------

  // one sram word
  typedef logic [`MEM_DATA_W-1:0] mem_word_t;

  // word index into the sram
  typedef logic [`MEM_LINE_W-1:0] mem_line_t;

  // -------------------------------------------------------------------------
  // port to sram request
  // -------------------------------------------------------------------------

  // presented on clk_mem by a bus port
  typedef struct packed
  {
    // addressed line
    mem_line_t line;
    // write strobe, only in the acknowledge cycle of a legal write
    logic      wen;
    // word to store
    mem_word_t wdata;
  } sram_access_t;

  // read data follows the line by one clk_mem cycle,
  // writes land on the clk_mem edge that samples wen

endpackage

//--- rtl/dual_port_sram.sv
// shared two-port sram
`timescale 1ns/100ps
`include "mem_config.svh"

module dual_port_sram
(
  input  logic                  clk_mem,
  // instruction side, read only
  input  mem_pkg::mem_line_t    rd_line,
  output mem_pkg::mem_word_t    rd_data,
  // data side, read or write
  input  mem_pkg::sram_access_t rw_access,
  output mem_pkg::mem_word_t    rw_data
);
  import mem_pkg::*;

  // storage, no reset and no preload
  mem_word_t mem_array [`MEM_LINES];

  // -------------------------------------------------------------------------
  // port 1, read only
  // -------------------------------------------------------------------------

  // registered read
  // same-line write on port 2 in this cycle is not seen, old word returns
  always_ff @(posedge clk_mem)
  begin
    rd_data <= mem_array[rd_line];
  end

  // -------------------------------------------------------------------------
  // port 2, read/write
  // -------------------------------------------------------------------------

  // write on wen, otherwise registered read
  always_ff @(posedge clk_mem)
  begin
    if (rw_access.wen)
    begin
      mem_array[rw_access.line] <= rw_access.wdata;
    end
    else
    begin
      rw_data <= mem_array[rw_access.line];
    end
  end

  // -------------------------------------------------------------------------
  // checks
  // -------------------------------------------------------------------------

  // port line register must be settled before any write strobe
  a_wen_line_known: assert property (@(posedge clk_mem)
    rw_access.wen |-> !$isunknown(rw_access.line))
    else $error("sram write with unknown line");

endmodule

//--- rtl/ahb_mem_port.sv
// ahb-lite memory slave port
`timescale 1ns/100ps
`include "mem_config.svh"

module ahb_mem_port
#(
  // 1 for the instruction port, writes are refused
  parameter bit read_only = 1'b0
)
(
  input  logic                       clk_l2,
  input  logic                       clk_mem,
  input  logic                       rst_n,
  input  logic                       hsel,
  input  ahb_lite_pkg::mas_send_type bus_in,
  output ahb_lite_pkg::slv_send_type bus_out,
  output mem_pkg::sram_access_t      sram_req,
  input  mem_pkg::mem_word_t         sram_rdata
);
  import ahb_lite_pkg::*;
  import mem_pkg::*;

  // access check
  logic      misaligned;
  logic      out_of_range;
  logic      ro_write;
  logic      acc_err;
  // clk_l2 side
  logic      req;
  logic      err_q;
  logic      rsp_ready;
  logic      rsp_resp;
  mem_word_t rsp_data;
  // clk_mem side
  logic      ack;
  logic      ack_dl;
  mem_line_t line_q;
  mem_word_t wdata_q;
  logic      write_q;

  // -------------------------------------------------------------------------
  // access check, decided once per request
  // -------------------------------------------------------------------------

  assign misaligned   = |bus_in.haddr[1:0];
  // word index past the end of the sram
  assign out_of_range = (bus_in.haddr[`MEM_ADDR_W-1:2] >= `MEM_LINES);
  assign ro_write     = read_only && bus_in.hwrite;
  assign acc_err      = misaligned | out_of_range | ro_write;

  // -------------------------------------------------------------------------
  // clk_l2 request flag
  // -------------------------------------------------------------------------

  // set on hsel once the previous ack and its delayed copy are gone,
  // error flag is captured together with the request
  always_ff @(posedge clk_l2, negedge rst_n)
  begin
    if (!rst_n)
    begin
      req   <= 1'b0;
      err_q <= 1'b0;
    end
    else if (hsel && !req && !ack && !ack_dl)
    begin
      req   <= 1'b1;
      err_q <= acc_err;
    end
    else if (ack)
    begin
      req <= 1'b0;
    end
  end

  // -------------------------------------------------------------------------
  // clk_mem acknowledge
  // -------------------------------------------------------------------------

  // ack one clk_mem cycle behind req, ack_dl keeps the port closed
  // until the ack has fully drained
  always_ff @(posedge clk_mem, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack    <= 1'b0;
      ack_dl <= 1'b0;
    end
    else
    begin
      ack    <= req;
      ack_dl <= ack;
    end
  end

  // request payload, frozen while ack is high
  always_ff @(posedge clk_mem)
  begin
    if (!ack)
    begin
      line_q  <= bus_in.haddr[`MEM_LINE_W+1:2];
      wdata_q <= bus_in.hwdata;
      write_q <= bus_in.hwrite;
    end
  end

  // write strobe only in the first ack cycle of a legal write
  assign sram_req = '{line:  line_q,
                      wen:   ack & ~ack_dl & write_q & ~err_q & ~read_only,
                      wdata: wdata_q};

  // -------------------------------------------------------------------------
  // clk_l2 response
  // -------------------------------------------------------------------------

  // one cycle pulse when the ack is seen
  always_ff @(posedge clk_l2, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rsp_ready <= 1'b0;
      rsp_resp  <= hresp_okay;
    end
    else
    begin
      rsp_ready <= req & ack;
      rsp_resp  <= (req && ack && err_q) ? hresp_error : hresp_okay;
    end
  end

  // read word, meaningless on write or error
  always_ff @(posedge clk_l2)
  begin
    if (req && ack)
    begin
      rsp_data <= sram_rdata;
    end
  end

  assign bus_out = '{hreadyout: rsp_ready, hresp: rsp_resp, hrdata: rsp_data};

  // -------------------------------------------------------------------------
  // checks
  // -------------------------------------------------------------------------

  a_single_pulse: assert property (@(posedge clk_l2) disable iff (!rst_n)
    rsp_ready |=> !rsp_ready)
    else $error("hreadyout high on two consecutive cycles");

  // sram writes only inside a live, legal request of a writable port
  a_wen_legal: assert property (@(posedge clk_mem) disable iff (!rst_n)
    sram_req.wen |-> (!read_only && req && !err_q))
    else $error("sram write outside a legal request");

endmodule

//--- rtl/renas_memory.sv
// renas mcu main memory
`timescale 1ns/100ps

module renas_memory
(
  // instruction fetch port
  input  logic                       imem_hsel,
  input  ahb_lite_pkg::mas_send_type imem_in,
  output ahb_lite_pkg::slv_send_type imem_out,
  // data load/store port
  input  logic                       dmem_hsel,
  input  ahb_lite_pkg::mas_send_type dmem_in,
  output ahb_lite_pkg::slv_send_type dmem_out,
  // system
  input  logic                       clk_l2,
  input  logic                       clk_mem,
  input  logic                       rst_n
);
  import mem_pkg::*;

  // port to sram requests
  sram_access_t imem_sram_req;
  sram_access_t dmem_sram_req;
  // sram read words back to the ports
  mem_word_t    imem_rdata;
  mem_word_t    dmem_rdata;

  // -------------------------------------------------------------------------
  // bus ports
  // -------------------------------------------------------------------------

  // instruction side, writes answered with error
  ahb_mem_port
  #(
    .read_only (1'b1)
  )
  u_imem_port
  (
    .clk_l2     (clk_l2),
    .clk_mem    (clk_mem),
    .rst_n      (rst_n),
    .hsel       (imem_hsel),
    .bus_in     (imem_in),
    .bus_out    (imem_out),
    .sram_req   (imem_sram_req),
    .sram_rdata (imem_rdata)
  );

  // data side, full word reads and writes
  ahb_mem_port
  #(
    .read_only (1'b0)
  )
  u_dmem_port
  (
    .clk_l2     (clk_l2),
    .clk_mem    (clk_mem),
    .rst_n      (rst_n),
    .hsel       (dmem_hsel),
    .bus_in     (dmem_in),
    .bus_out    (dmem_out),
    .sram_req   (dmem_sram_req),
    .sram_rdata (dmem_rdata)
  );

  // -------------------------------------------------------------------------
  // shared sram
  // -------------------------------------------------------------------------

  // imem only needs the line, its strobe is always low
  dual_port_sram u_sram
  (
    .clk_mem   (clk_mem),
    .rd_line   (imem_sram_req.line),
    .rd_data   (imem_rdata),
    .rw_access (dmem_sram_req),
    .rw_data   (dmem_rdata)
  );

endmodule

//--- tests/renas_memory_tb.sv
// main memory directed testbench
`timescale 1ns/100ps
`include "mem_config.svh"

module renas_memory_tb;
  import ahb_lite_pkg::*;
  import mem_pkg::*;

  logic         clk_l2;
  logic         clk_mem;
  logic         rst_n;
  logic         imem_hsel;
  mas_send_type imem_in;
  slv_send_type imem_out;
  logic         dmem_hsel;
  mas_send_type dmem_in;
  slv_send_type dmem_out;

  // reference copy of the sram
  // only written lines are ever read
  mem_word_t    model [`MEM_LINES];
  int           written_lines [10];
  integer       seed;
  // responses captured by concurrent accesses
  slv_send_type d_resp;
  slv_send_type i_resp;

  renas_memory u_renas_memory
  (
    .imem_hsel (imem_hsel),
    .imem_in   (imem_in),
    .imem_out  (imem_out),
    .dmem_hsel (dmem_hsel),
    .dmem_in   (dmem_in),
    .dmem_out  (dmem_out),
    .clk_l2    (clk_l2),
    .clk_mem   (clk_mem),
    .rst_n     (rst_n)
  );

  // clk_l2 at 20 ns and clk_mem at 10 ns with rising edges aligned
  always #10 clk_l2 = ~clk_l2;
  always #5 clk_mem = ~clk_mem;

  // --------------------------------------------------------------------------
  // checking
  // --------------------------------------------------------------------------

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  // completion pulse and error flag only
  // hrdata goes through compare_word
  task automatic compare_resp(input string sig, input slv_send_type exp,
                              input slv_send_type act);
    if (act.hreadyout !== exp.hreadyout)
    begin
      stop_run($sformatf("Fail at time %0t: %s.hreadyout expected %b, got %b",
                         $time, sig, exp.hreadyout, act.hreadyout));
    end
    if (act.hresp !== exp.hresp)
    begin
      stop_run($sformatf("Fail at time %0t: %s.hresp expected %b, got %b",
                         $time, sig, exp.hresp, act.hresp));
    end
  endtask

  task automatic compare_word(input string sig, input mem_word_t exp, input mem_word_t act);
    if (act !== exp)
    begin
      stop_run($sformatf("Fail at time %0t: %s expected %h, got %h", $time, sig, exp, act));
    end
  endtask

  // expected response in the pulse cycle
  function automatic slv_send_type pulse_resp(input logic err);
    slv_send_type r;
    r           = '0;
    r.hreadyout = 1'b1;
    r.hresp     = err;
    return r;
  endfunction

  function automatic logic [`MEM_ADDR_W-1:0] line_addr(input mem_line_t line);
    return `MEM_ADDR_W'(line) << 2;
  endfunction

  // --------------------------------------------------------------------------
  // bus drivers entered and left 2 ns after a clk_l2 edge
  // --------------------------------------------------------------------------

  // hold request until the pulse and expect the port idle after it
  task automatic dmem_access(input logic wr, input logic [`MEM_ADDR_W-1:0] addr,
                             input mem_word_t wdata, output slv_send_type resp);
    int cycles;
    cycles         = 0;
    dmem_in.haddr  = addr;
    dmem_in.hwrite = wr;
    dmem_in.hwdata = wdata;
    dmem_hsel      = 1'b1;
    @(posedge clk_l2);
    #2;
    while (dmem_out.hreadyout !== 1'b1)
    begin
      cycles++;
      if (cycles >= 20)
        stop_run("no response from port dmem within 20 clk_l2 cycles");
      @(posedge clk_l2);
      #2;
    end
    resp      = dmem_out;
    dmem_hsel = 1'b0;
    dmem_in   = '0;
    @(posedge clk_l2);
    #2;
    // pulse lasts one cycle only
    compare_resp("dmem_out", '0, dmem_out);
  endtask

  task automatic imem_access(input logic wr, input logic [`MEM_ADDR_W-1:0] addr,
                             input mem_word_t wdata, output slv_send_type resp);
    int cycles;
    cycles         = 0;
    imem_in.haddr  = addr;
    imem_in.hwrite = wr;
    imem_in.hwdata = wdata;
    imem_hsel      = 1'b1;
    @(posedge clk_l2);
    #2;
    while (imem_out.hreadyout !== 1'b1)
    begin
      cycles++;
      if (cycles >= 20)
        stop_run("no response from port imem within 20 clk_l2 cycles");
      @(posedge clk_l2);
      #2;
    end
    resp      = imem_out;
    imem_hsel = 1'b0;
    imem_in   = '0;
    @(posedge clk_l2);
    #2;
    compare_resp("imem_out", '0, imem_out);
  endtask

  // legal word write through dmem with model update
  task automatic write_word(input mem_line_t line, input mem_word_t data);
    slv_send_type resp;
    dmem_access(1'b1, line_addr(line), data, resp);
    compare_resp("dmem_out", pulse_resp(1'b0), resp);
    model[line] = data;
  endtask

  task automatic read_word(input mem_line_t line);
    slv_send_type resp;
    dmem_access(1'b0, line_addr(line), '0, resp);
    compare_resp("dmem_out", pulse_resp(1'b0), resp);
    compare_word("dmem_out.hrdata", model[line], resp.hrdata);
  endtask

  task automatic fetch_word(input mem_line_t line);
    slv_send_type resp;
    imem_access(1'b0, line_addr(line), '0, resp);
    compare_resp("imem_out", pulse_resp(1'b0), resp);
    compare_word("imem_out.hrdata", model[line], resp.hrdata);
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  // both ports quiet with hsel low
  task automatic reset_idle();
    repeat (5)
    begin
      @(posedge clk_l2);
      #2;
      compare_resp("imem_out", '0, imem_out);
      compare_resp("dmem_out", '0, dmem_out);
    end
  endtask

  // includes line 0 and the last line for the error test
  task automatic write_read_back();
    written_lines = '{0, 1, 2, 3, 5, 8, 13, 100, 512, `MEM_LINES-1};
    foreach (written_lines[i])
      write_word(mem_line_t'(written_lines[i]), $random(seed));
    foreach (written_lines[i])
      read_word(mem_line_t'(written_lines[i]));
  endtask

  // same words seen from the fetch side
  task automatic shared_fetch();
    foreach (written_lines[i])
      fetch_word(mem_line_t'(written_lines[i]));
  endtask

  // misaligned and out of range addresses
  // some alias onto line 0 or the last line
  task automatic data_port_errors();
    logic [`MEM_ADDR_W-1:0] bad_addr [5];
    slv_send_type           resp;
    bad_addr = '{32'h0000_0001, 32'h0000_0ffe, 32'h0000_1000, 32'h0000_1ffc, 32'h8000_0000};
    foreach (bad_addr[i])
    begin
      dmem_access(i != 1, bad_addr[i], 32'hdead_0000 + i, resp);
      compare_resp("dmem_out", pulse_resp(1'b1), resp);
    end
    read_word('0);
    read_word(mem_line_t'(`MEM_LINES-1));
  endtask

  // fetch port refuses writes
  task automatic imem_write_refused();
    slv_send_type resp;
    imem_access(1'b1, line_addr(5), 32'h5a5a_a5a5, resp);
    compare_resp("imem_out", pulse_resp(1'b1), resp);
    read_word(5);
  endtask

  // dmem traffic on lines 64..127 with concurrent fetches from other lines
  task automatic random_traffic();
    int        r;
    int        d_off;
    int        i_off;
    logic      wr;
    mem_word_t wdata;
    mem_word_t exp_i;
    for (int i = 64; i < 128; i++)
      write_word(mem_line_t'(i), $random(seed));
    for (int n = 0; n < 60; n++)
    begin
      r     = $random(seed);
      d_off = r[5:0];
      // offset 1..63 keeps the fetch off the data line
      i_off = (d_off + 1 + (r[13:8] % 63)) % 64;
      wr    = r[16];
      wdata = $random(seed);
      exp_i = model[64 + i_off];
      fork
        dmem_access(wr, line_addr(mem_line_t'(64 + d_off)), wdata, d_resp);
        imem_access(1'b0, line_addr(mem_line_t'(64 + i_off)), '0, i_resp);
      join
      compare_resp("dmem_out", pulse_resp(1'b0), d_resp);
      compare_resp("imem_out", pulse_resp(1'b0), i_resp);
      compare_word("imem_out.hrdata", exp_i, i_resp.hrdata);
      if (wr)
        model[64 + d_off] = wdata;
      else
        compare_word("dmem_out.hrdata", model[64 + d_off], d_resp.hrdata);
    end
  endtask

  // --------------------------------------------------------------------------
  // sequence
  // --------------------------------------------------------------------------

  initial
  begin
    seed      = 93;
    clk_l2    = 1'b0;
    // starts high so its rising edges meet those of clk_l2
    clk_mem   = 1'b1;
    rst_n     = 1'b0;
    imem_hsel = 1'b0;
    dmem_hsel = 1'b0;
    imem_in   = '0;
    dmem_in   = '0;
    repeat (10) @(posedge clk_l2);
    #2;
    rst_n = 1'b1;
    reset_idle();
    write_read_back();
    shared_fetch();
    data_port_errors();
    imem_write_refused();
    random_traffic();
    $display("All tests passed");
    $finish;
  end

endmodule

//--- tb.f
+incdir+rtl
rtl/ahb_lite_pkg.sv
rtl/mem_pkg.sv
rtl/dual_port_sram.sv
rtl/ahb_mem_port.sv
rtl/renas_memory.sv
tests/renas_memory_tb.sv

//--- Bender.yml
package:
  name: renas_memory

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ahb_lite_pkg.sv
      - rtl/mem_pkg.sv
      - rtl/dual_port_sram.sv
      - rtl/ahb_mem_port.sv
      - rtl/renas_memory.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/renas_memory_tb.sv
